// File: list.f
rtl/fp_format_pkg.sv
rtl/fp_datapath_pkg.sv
rtl/fp_preadder.sv
rtl/fp_special_case.sv
rtl/fp_normalize_round.sv
rtl/fp_adder.sv
rtl/fp_add_unit.sv
tests/tb_clock_gen.sv
tests/tb_fp_add_unit.sv

// File: run.sh
#!/bin/sh
set -e

verilator --binary --timing --assert -j 0 \
  --top-module tb_fp_add_unit \
  -f list.f \
  -o sim_fp_add_unit

output=$(./obj_dir/sim_fp_add_unit)
printf '%s\n' "$output"

echo "$output" | grep -q "NO ERRORS"

// File: tests/tb_fp_add_unit.sv
`default_nettype none
`timescale 1ns/10ps

module tb_fp_add_unit;

  localparam int N_NORMAL  = 2000;
  localparam int N_CANCEL  = 300;
  localparam int N_TIES    = 300;
  localparam int N_RANGE   = 300;
  localparam int N_SPECIAL = 400;
  localparam int N_PIPE    = 400;
  localparam int MAX_GAP   = 3;
  localparam int LIMIT_CYCLES = N_NORMAL + N_CANCEL + N_TIES + N_RANGE + N_SPECIAL
                              + N_PIPE + N_PIPE * MAX_GAP + 100;
  localparam logic [31:0] QNAN = 32'h7fc0_0000;

  logic        clk, reset;
  logic        in_valid, subtract;
  logic [31:0] a, b;
  logic        out_valid, flag_invalid, flag_overflow;
  logic [31:0] result;
  int          test_id;

  logic [33:0] want_q[$];                  // {invalid, overflow, result}
  int          due_q[$];
  int          id_q[$];
  int          edge_count = 0;
  int          ops_seen = 0;
  int          pulses = 0;
  int          value_errors = 0;
  int          protocol_errors = 0;

  tb_clock_gen tb_clock_gen_inst (.clk(clk), .reset(reset));

  fp_add_unit fp_add_unit_inst (
    .clk           (clk),
    .reset         (reset),
    .in_valid      (in_valid),
    .a             (a),
    .b             (b),
    .subtract      (subtract),
    .out_valid     (out_valid),
    .flag_invalid  (flag_invalid),
    .flag_overflow (flag_overflow),
    .result        (result)
  );

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic real to_real(input logic [31:0] w);
    logic [10:0] de;
    de = {3'b000, w[30:23]} + 11'd896;     // Rebias 127 to 1023
    return $bitstoreal({w[31], de, w[22:0], 29'h0});
  endfunction

  // Nearest even at 24 bits, then range limits
  function automatic logic [33:0] round_single(input real r);
    logic [63:0] d;
    logic [24:0] sig;
    logic [28:0] tail;
    int          e;
    d    = $realtobits(r);
    e    = int'(d[62:52]) - 896;
    sig  = {2'b01, d[51:29]};
    tail = d[28:0];
    if (tail > 29'h1000_0000 || (tail == 29'h1000_0000 && sig[0])) sig = sig + 25'd1;
    if (sig[24]) begin
      sig = sig >> 1;
      e   = e + 1;
    end
    if (e >= 255) return {2'b01, d[63], 8'hff, 23'h0};
    if (e <= 0) return {2'b00, d[63], 31'h0};
    return {2'b00, d[63], e[7:0], sig[22:0]};
  endfunction

  function automatic logic [33:0] expected_sum(input logic [31:0] x, input logic [31:0] y,
                                               input logic sub);
    logic ys;
    logic x_nan, y_nan, x_inf, y_inf, x_zero, y_zero;
    real  sum_r;
    ys     = y[31] ^ sub;                  // Sign of y as it enters the sum
    x_zero = (x[30:23] == 8'h00);          // Subnormals count as zero
    y_zero = (y[30:23] == 8'h00);
    x_inf  = (x[30:23] == 8'hff) && (x[22:0] == 23'h0);
    y_inf  = (y[30:23] == 8'hff) && (y[22:0] == 23'h0);
    x_nan  = (x[30:23] == 8'hff) && (x[22:0] != 23'h0);
    y_nan  = (y[30:23] == 8'hff) && (y[22:0] != 23'h0);
    if (x_nan || y_nan) return {2'b00, QNAN};
    if (x_inf && y_inf) return (x[31] != ys) ? {2'b10, QNAN} : {2'b00, x[31], 8'hff, 23'h0};
    if (x_inf) return {2'b00, x[31], 8'hff, 23'h0};
    if (y_inf) return {2'b00, ys, 8'hff, 23'h0};
    if (x_zero && y_zero) return {2'b00, x[31] & ys, 31'h0};
    if (x_zero) return {2'b00, ys, y[30:0]};
    if (y_zero) return {2'b00, x};
    sum_r = sub ? to_real(x) - to_real(y) : to_real(x) + to_real(y);
    if (sum_r == 0.0) return 34'h0;        // Exact cancellation, +0
    return round_single(sum_r);
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1:       return "normal add/sub";
      2:       return "cancellation";
      3:       return "ties";
      4:       return "overflow/flush";
      5:       return "special operands";
      default: return "pipeline timing";
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic logic coin();
    logic [31:0] r;
    r = $urandom;
    return r[0];
  endfunction

  function automatic int clamp_exp(input int e);
    if (e < 1) return 1;
    if (e > 254) return 254;
    return e;
  endfunction

  function automatic logic [31:0] rand_normal(input int e);
    logic [31:0] r;
    r = $urandom;
    return {r[31], 8'(e), r[22:0]};
  endfunction

  function automatic logic [31:0] special_operand();
    logic [31:0] r;
    r = $urandom;
    case (r[30:28])
      3'd0:    return {r[31], 31'h0};
      3'd1:    return {r[31], 8'h00, r[22:0] | 23'h1};
      3'd2:    return {r[31], 8'hff, 23'h0};
      3'd3:    return {r[31], 8'hff, r[22:0] | 23'h1};
      default: return rand_normal(1 + int'(r[27:20]) % 254);
    endcase
  endfunction

  task automatic send_op(input logic [31:0] x, input logic [31:0] y, input logic sub,
                         input int id);
    @(posedge clk);
    a        <= x;
    b        <= y;
    subtract <= sub;
    in_valid <= 1'b1;
    test_id  <= id;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Monitor and checks, sampled on the falling edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk) edge_count <= edge_count + 1;

  always @(negedge clk) begin
    logic [33:0] want;
    int          id;
    int          due;
    logic        late;
    if (reset) begin
      assert (!out_valid)
        else begin
          protocol_errors++;
          $display("out_valid was high while reset was asserted");
        end
    end else begin
      late = !out_valid && due_q.size() != 0 && due_q[0] <= edge_count;
      assert (!late)
        else begin
          protocol_errors++;
          $display("No out_valid for a %s operation due at edge %0d", test_name(id_q[0]),
                   due_q[0]);
        end
      if (late) begin
        void'(want_q.pop_front());
        void'(due_q.pop_front());
        void'(id_q.pop_front());
      end
      if (out_valid) begin
        pulses++;
        assert (want_q.size() != 0)
          else begin
            protocol_errors++;
            $display("out_valid pulse at edge %0d with no operation in flight", edge_count);
          end
        if (want_q.size() != 0) begin
          want = want_q.pop_front();
          due  = due_q.pop_front();
          id   = id_q.pop_front();
          assert (due == edge_count)
            else begin
              protocol_errors++;
              $display("Result for %s came at edge %0d instead of edge %0d", test_name(id),
                       edge_count, due);
            end
          assert (result == want[31:0])
            else begin
              value_errors++;
              $display("Error %s: expected %h, actual %h", test_name(id), want[31:0], result);
            end
          assert ({flag_invalid, flag_overflow} == want[33:32])
            else begin
              value_errors++;
              $display("Error %s flags: expected %b, actual %b", test_name(id), want[33:32],
                       {flag_invalid, flag_overflow});
            end
        end
      end
      if (in_valid) begin
        want_q.push_back(expected_sum(a, b, subtract));
        due_q.push_back(edge_count + 2);   // Two rising edges after the drive edge
        id_q.push_back(test_id);
        ops_seen++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          ea, eb, k;
    logic [31:0] x, y, mask;
    void'($urandom(32'h3f6a_121a));
    in_valid = 1'b0;
    subtract = 1'b0;
    a        = 32'h0;
    b        = 32'h0;
    test_id  = 0;
    wait (!reset);

    for (int i = 0; i < N_NORMAL; i++) begin
      ea = 1 + int'($urandom % 254);
      eb = clamp_exp(ea + int'($urandom % 61) - 30);
      send_op(rand_normal(ea), rand_normal(eb), coin(), 1);
    end

    for (int i = 0; i < N_CANCEL; i++) begin
      x    = rand_normal(1 + int'($urandom % 254));
      k    = int'($urandom % 24);
      mask = (32'd1 << k) - 32'd1;         // k of zero gives an exact match
      y    = x ^ ($urandom & mask);
      if (coin()) send_op(x, y, 1'b1, 2);
      else send_op(x, y ^ 32'h8000_0000, 1'b0, 2);
    end

    for (int i = 0; i < N_TIES; i++) begin
      ea = 2 + int'($urandom % 252);
      k  = int'($urandom % 3);
      x  = rand_normal(ea);
      if (coin()) x[22:0] = '1;            // Rounding carries into the exponent
      y    = rand_normal(ea - k);
      mask = (32'd1 << k) - 32'd1;
      y    = (y & ~mask) | (mask & ~(mask >> 1));   // Bits lost in alignment = one half
      send_op(x, y, coin(), 3);
    end

    for (int i = 0; i < N_RANGE; i++) begin
      if (coin()) begin
        ea = 250 + int'($urandom % 5);
        send_op(rand_normal(ea), rand_normal(ea - int'($urandom % 3)), coin(), 4);
      end else begin
        x = rand_normal(1 + int'($urandom % 4));
        y = x ^ ($urandom & 32'h007f_ffff);
        send_op(x, y, 1'b1, 4);
      end
    end

    for (int i = 0; i < N_SPECIAL; i++) begin
      send_op(special_operand(), special_operand(), coin(), 5);
    end

    for (int i = 0; i < N_PIPE; i++) begin
      ea = 1 + int'($urandom % 254);
      eb = clamp_exp(ea + int'($urandom % 61) - 30);
      send_op(rand_normal(ea), rand_normal(eb), coin(), 6);
      idle_cycles(int'($urandom % (MAX_GAP + 1)));
    end
    idle_cycles(1);

    while (want_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);             // Catch any stray pulse
    assert (pulses == ops_seen)
      else begin
        protocol_errors++;
        $display("Saw %0d out_valid pulses for %0d operations", pulses, ops_seen);
      end

    $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(LIMIT_CYCLES * 10);
    $display("Watchdog expired after %0d cycles, %0d results still outstanding",
             LIMIT_CYCLES, want_q.size());
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                 // 10 ns period
  end

  // Held through the first two rising edges
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: rtl/fp_add_unit.sv
`default_nettype none
`timescale 1ns/10ps

module fp_add_unit (
  input  logic        clk,
  input  logic        reset,
  input  logic        in_valid,
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic        subtract,
  output logic        out_valid,
  output logic        flag_invalid,
  output logic        flag_overflow,
  output logic [31:0] result
);
  import fp_format_pkg::*;

  logic [31:0] a_q, b_q;
  logic        subtract_q;
  logic        valid_q;
  logic [31:0] core_sum;
  logic        core_invalid, core_overflow;

  ////////////////////////////////////////////////////////////
  // Stage 1 operand capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      a_q        <= a;
      b_q        <= b;
      subtract_q <= subtract;
    end
  end

  fp_adder fp_adder_inst (
    .a        (a_q),
    .b        (b_q),
    .subtract (subtract_q),
    .sum      (core_sum),
    .invalid  (core_invalid),
    .overflow (core_overflow)
  );

  ////////////////////////////////////////////////////////////
  // Stage 2 result capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid     <= 1'b0;
      flag_invalid  <= 1'b0;
      flag_overflow <= 1'b0;
    end else begin
      out_valid     <= valid_q;
      flag_invalid  <= valid_q & core_invalid;    // Flags only with a result
      flag_overflow <= valid_q & core_overflow;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_q) begin
      result <= core_sum;
    end
  end

  out_valid_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(out_valid))
    else $error("fp_add_unit: out_valid unknown after reset");

  // Overflow flag and infinity result leave together
  overflow_is_inf: assert property (@(posedge clk) disable iff (reset)
    flag_overflow |-> (out_valid && result[MAN_W +: EXP_W] == EXP_MAX))
    else $error("fp_add_unit: overflow flagged without an infinite result");

endmodule

`default_nettype wire

// File: rtl/fp_adder.sv
`default_nettype none
`timescale 1ns/10ps

module fp_adder (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic        subtract,
  output logic [31:0] sum,
  output logic        invalid,
  output logic        overflow
);
  import fp_format_pkg::*;
  import fp_datapath_pkg::*;

  fp32_word_u       a_word, b_word;
  fp_class_e        a_class, b_class;
  logic             big_sign, small_sign, swapped;
  logic [EXP_W-1:0] exponent;
  logic [EXT_W-1:0] big_mantissa, small_mantissa;
  logic [EXT_W-1:0] small_operand, raw_sum;
  logic             big_eff_sign, small_eff_sign, eff_sub;
  logic             special_hit, special_invalid;
  logic [31:0]      special_word, norm_word;
  logic             norm_overflow;

  assign a_word.raw = a;
  assign b_word.raw = b;

  fp_preadder fp_preadder_inst (
    .a              (a),
    .b              (b),
    .a_class        (a_class),
    .b_class        (b_class),
    .big_sign       (big_sign),
    .small_sign     (small_sign),
    .swapped        (swapped),
    .exponent       (exponent),
    .big_mantissa   (big_mantissa),
    .small_mantissa (small_mantissa)
  );

  fp_special_case fp_special_case_inst (
    .a               (a),
    .b               (b),
    .a_class         (a_class),
    .b_class         (b_class),
    .subtract        (subtract),
    .special_hit     (special_hit),
    .special_invalid (special_invalid),
    .special_word    (special_word)
  );

  ////////////////////////////////////////////////////////////
  // Effective operation and mantissa add
  ////////////////////////////////////////////////////////////

  // The operation flips b, wherever the swap put it
  assign big_eff_sign   = swapped ? (big_sign ^ subtract) : big_sign;
  assign small_eff_sign = swapped ? small_sign : (small_sign ^ subtract);
  assign eff_sub        = big_eff_sign ^ small_eff_sign;

  // Two's complement of the smaller one, the difference never goes negative
  assign small_operand = small_mantissa ^ {EXT_W{eff_sub}};
  assign raw_sum       = big_mantissa + small_operand + EXT_W'(eff_sub);

  fp_normalize_round fp_normalize_round_inst (
    .raw_sum       (raw_sum),
    .exponent      (exponent),
    .sign          (big_eff_sign),                 // Larger magnitude sets the sign
    .norm_word     (norm_word),
    .norm_overflow (norm_overflow)
  );

  assign sum      = special_hit ? special_word : norm_word;
  assign invalid  = special_hit & special_invalid;
  assign overflow = ~special_hit & norm_overflow;

  // Only normal operands may reach the rounding path
  always_comb begin
    if (!$isunknown({a, b})) begin
      assert (special_hit
              || (a_word.fields.exponent != EXP_MAX && a_word.fields.exponent != '0
                  && b_word.fields.exponent != EXP_MAX && b_word.fields.exponent != '0))
        else $error("fp_adder: special operand missed by the special-case path");
    end
  end

endmodule

`default_nettype wire

// File: rtl/fp_normalize_round.sv
`default_nettype none
`timescale 1ns/10ps

module fp_normalize_round (
  input  logic [27:0] raw_sum,
  input  logic [7:0]  exponent,
  input  logic        sign,
  output logic [31:0] norm_word,
  output logic        norm_overflow
);
  import fp_format_pkg::*;
  import fp_datapath_pkg::*;

  logic                    carry;
  logic [SHIFT_W-1:0]      lead_zeros;
  logic [EXT_W-1:0]        aligned;
  logic signed [EXP_W+1:0] exp_norm, exp_final;   // Two spare bits for sign and overflow
  logic                    guard_bit, round_bit, sticky_bit, round_up;
  logic [MAN_W+1:0]        rounded;                // Carry out of rounding on top
  logic [MAN_W-1:0]        fraction;

  assign carry = raw_sum[CARRY_BIT];

  ////////////////////////////////////////////////////////////
  // Leading-zero count below the carry position
  ////////////////////////////////////////////////////////////

  always_comb begin
    lead_zeros = SHIFT_W'(EXT_W - 1);              // Nothing set at all
    for (int i = 0; i < EXT_W - 1; i++) begin
      if (raw_sum[i]) begin
        lead_zeros = SHIFT_W'(HIDDEN_BIT - i);     // Highest set bit wins
      end
    end
  end

  // Carry goes right by one, keeping the dropped bit as sticky
  always_comb begin
    if (carry) begin
      aligned  = {1'b0, raw_sum[EXT_W-1:2], raw_sum[1] | raw_sum[0]};
      exp_norm = $signed({2'b00, exponent}) + 10'sd1;
    end else begin
      aligned  = raw_sum << lead_zeros;
      exp_norm = $signed({2'b00, exponent})
               - $signed({{(EXP_W+2-SHIFT_W){1'b0}}, lead_zeros});
    end
  end

  // Leading one must land on the hidden bit
  always_comb begin
    if (!$isunknown(raw_sum)) begin
      assert (carry || raw_sum == '0 || aligned[HIDDEN_BIT])
        else $error("fp_normalize_round: shift by %0d missed the hidden bit", lead_zeros);
    end
  end

  ////////////////////////////////////////////////////////////
  // Round to nearest, ties to even
  ////////////////////////////////////////////////////////////

  assign guard_bit  = aligned[GRS_W-1];
  assign round_bit  = aligned[GRS_W-2];
  assign sticky_bit = aligned[GRS_W-3];
  assign round_up   = guard_bit & (round_bit | sticky_bit | aligned[GRS_W]);

  assign rounded = {1'b0, aligned[HIDDEN_BIT:GRS_W]} + (MAN_W+2)'(round_up);

  // Rounding carry leaves 1.000..., fraction becomes zero
  assign fraction  = rounded[MAN_W-1:0];
  assign exp_final = exp_norm + $signed({{(EXP_W+1){1'b0}}, rounded[MAN_W+1]});

  ////////////////////////////////////////////////////////////
  // Range checks and packing
  ////////////////////////////////////////////////////////////

  always_comb begin
    norm_overflow = 1'b0;
    if (raw_sum == '0) begin
      norm_word = '0;                              // Exact cancellation is +0
    end else if (exp_final >= $signed({2'b00, EXP_MAX})) begin
      norm_word     = {sign, EXP_MAX, {MAN_W{1'b0}}};
      norm_overflow = 1'b1;
    end else if (exp_final <= 0) begin
      norm_word = {sign, {(EXP_W+MAN_W){1'b0}}};   // Flush, sign kept
    end else begin
      norm_word = {sign, exp_final[EXP_W-1:0], fraction};
    end
  end

endmodule

`default_nettype wire

// File: rtl/fp_special_case.sv
`default_nettype none
`timescale 1ns/10ps

module fp_special_case (
  input  logic [31:0]              a,
  input  logic [31:0]              b,
  input  fp_format_pkg::fp_class_e a_class,
  input  fp_format_pkg::fp_class_e b_class,
  input  logic                     subtract,
  output logic                     special_hit,
  output logic                     special_invalid,
  output logic [31:0]              special_word
);
  import fp_format_pkg::*;
  import fp_datapath_pkg::*;

  fp32_word_u a_word, b_word;
  logic       b_eff_sign;                       // Sign of b once the operation is applied
  logic       a_nan, b_nan, a_inf, b_inf, a_zero, b_zero;

  assign a_word.raw = a;
  assign b_word.raw = b;

  assign b_eff_sign = b_word.fields.sign ^ subtract;

  assign a_nan  = (a_class == FP_NAN);
  assign b_nan  = (b_class == FP_NAN);
  assign a_inf  = (a_class == FP_INF);
  assign b_inf  = (b_class == FP_INF);
  assign a_zero = (a_class == FP_ZERO) || (a_class == FP_SUBNORMAL);
  assign b_zero = (b_class == FP_ZERO) || (b_class == FP_SUBNORMAL);

  assign special_hit = a_nan | b_nan | a_inf | b_inf | a_zero | b_zero;

  always_comb begin
    special_invalid = 1'b0;
    special_word    = a_word.raw;               // b zero, a passes as it came
    if (a_nan || b_nan) begin
      special_word = QNAN_WORD;
    end else if (a_inf && b_inf) begin
      // Infinities pulling opposite ways have no answer
      if (a_word.fields.sign != b_eff_sign) begin
        special_word    = QNAN_WORD;
        special_invalid = 1'b1;
      end else begin
        special_word = {a_word.fields.sign, EXP_MAX, {MAN_W{1'b0}}};
      end
    end else if (a_inf) begin
      special_word = {a_word.fields.sign, EXP_MAX, {MAN_W{1'b0}}};
    end else if (b_inf) begin
      special_word = {b_eff_sign, EXP_MAX, {MAN_W{1'b0}}};
    end else if (a_zero && b_zero) begin
      // Negative only for -0 plus -0
      special_word = {a_word.fields.sign & b_eff_sign, {(EXP_W+MAN_W){1'b0}}};
    end else if (a_zero) begin
      special_word = {b_eff_sign, b_word.fields.exponent, b_word.fields.mantissa};
    end
  end

endmodule

`default_nettype wire

// File: rtl/fp_preadder.sv
`default_nettype none
`timescale 1ns/10ps

module fp_preadder (
  input  logic [31:0]              a,
  input  logic [31:0]              b,
  output fp_format_pkg::fp_class_e a_class,
  output fp_format_pkg::fp_class_e b_class,
  output logic                     big_sign,
  output logic                     small_sign,
  output logic                     swapped,
  output logic [7:0]               exponent,
  output logic [27:0]              big_mantissa,
  output logic [27:0]              small_mantissa
);
  import fp_format_pkg::*;
  import fp_datapath_pkg::*;

  function automatic fp_class_e classify(input fp32_word_u w);
    fp_class_e cls;
    if (w.fields.exponent == '0) begin
      cls = (w.fields.mantissa == '0) ? FP_ZERO : FP_SUBNORMAL;
    end else if (w.fields.exponent == EXP_MAX) begin
      cls = (w.fields.mantissa == '0) ? FP_INF : FP_NAN;
    end else begin
      cls = FP_NORMAL;
    end
    return cls;
  endfunction

  fp32_word_u             a_word, b_word;
  logic [EXP_W+MAN_W-1:0] a_mag, b_mag;     // Exponent and fraction, sign dropped
  logic [EXP_W+MAN_W-1:0] big_mag, small_mag;
  logic [EXP_W-1:0]       big_exp, small_exp, exp_diff;
  logic [EXT_W-1:0]       small_ext, small_shifted, lost_mask;
  logic                   sticky;

  assign a_word.raw = a;
  assign b_word.raw = b;

  assign a_class = classify(a_word);
  assign b_class = classify(b_word);

  // Subnormals flushed, they carry no magnitude into the datapath
  assign a_mag = (a_class == FP_ZERO || a_class == FP_SUBNORMAL) ? '0 :
                 {a_word.fields.exponent, a_word.fields.mantissa};
  assign b_mag = (b_class == FP_ZERO || b_class == FP_SUBNORMAL) ? '0 :
                 {b_word.fields.exponent, b_word.fields.mantissa};

  ////////////////////////////////////////////////////////////
  // Order by magnitude
  ////////////////////////////////////////////////////////////

  // Exponent sits above the fraction, so one compare orders both
  assign swapped    = (b_mag > a_mag);
  assign big_mag    = swapped ? b_mag : a_mag;
  assign small_mag  = swapped ? a_mag : b_mag;
  assign big_sign   = swapped ? b_word.fields.sign : a_word.fields.sign;
  assign small_sign = swapped ? a_word.fields.sign : b_word.fields.sign;

  assign big_exp   = big_mag[MAN_W +: EXP_W];
  assign small_exp = small_mag[MAN_W +: EXP_W];
  assign exp_diff  = big_exp - small_exp;
  assign exponent  = big_exp;

  ////////////////////////////////////////////////////////////
  // Hidden bit and alignment
  ////////////////////////////////////////////////////////////

  assign big_mantissa = {1'b0, |big_exp, big_mag[MAN_W-1:0], {GRS_W{1'b0}}};
  assign small_ext    = {1'b0, |small_exp, small_mag[MAN_W-1:0], {GRS_W{1'b0}}};

  assign small_shifted = small_ext >> exp_diff;
  assign lost_mask     = ~({EXT_W{1'b1}} << exp_diff);   // All ones once diff reaches EXT_W
  assign sticky        = |(small_ext & lost_mask);

  assign small_mantissa = {small_shifted[EXT_W-1:1], small_shifted[0] | sticky};

  // Subtraction in fp_adder relies on this ordering
  always_comb begin
    if (!$isunknown({a, b})) begin
      assert (big_mantissa >= small_mantissa)
        else $error("fp_preadder: aligned mantissa %h above larger %h",
                    small_mantissa, big_mantissa);
    end
  end

endmodule

`default_nettype wire

// File: rtl/fp_datapath_pkg.sv
`default_nettype none

package fp_datapath_pkg;

  ////////////////////////////////////////////////////////////
  // Extended mantissa used between alignment and rounding
  ////////////////////////////////////////////////////////////

  // carry | hidden | 23 fraction bits | guard | round | sticky
  localparam int EXT_W = 28;

  localparam int GRS_W      = 3;              // Guard, round and sticky
  localparam int HIDDEN_BIT = EXT_W - 2;      // Leading one of a normal value
  localparam int CARRY_BIT  = EXT_W - 1;      // Set only by an effective add

  // Leading-zero count and shift amount
  localparam int SHIFT_W = 5;

  ////////////////////////////////////////////////////////////
  // Canonical results
  ////////////////////////////////////////////////////////////

  // Quiet NaN with only the top fraction bit set
  localparam logic [31:0] QNAN_WORD = 32'h7fc0_0000;

endpackage

`default_nettype wire

// File: rtl/fp_format_pkg.sv
`default_nettype none

package fp_format_pkg;

  ////////////////////////////////////////////////////////////
  // IEEE 754 single-precision layout
  ////////////////////////////////////////////////////////////

  localparam int EXP_W  = 8;                  // Biased exponent field
  localparam int MAN_W  = 23;                 // Stored fraction, hidden bit not included
  localparam int WORD_W = 1 + EXP_W + MAN_W;

  // All-ones exponent marks infinity and NaN
  localparam logic [EXP_W-1:0] EXP_MAX = {EXP_W{1'b1}};

  // Operand class, same codes as the original adder
  typedef enum logic [2:0] {
    FP_ZERO      = 3'd0,
    FP_SUBNORMAL = 3'd1,
    FP_INF       = 3'd2,
    FP_NAN       = 3'd3,
    FP_NORMAL    = 3'd4
  } fp_class_e;

  // Field view of one operand word
  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exponent;
    logic [MAN_W-1:0] mantissa;
  } fp32_fields_s;

  // Raw bus word or decoded fields, same 32 bits
  typedef union packed {
    logic [WORD_W-1:0] raw;
    fp32_fields_s      fields;
  } fp32_word_u;

endpackage

`default_nettype wire
